//--- hdl/fe_defines.svh
// ====================
// Widths and fixed values shared by the instruction front end
// Addresses and instruction words are both 32 bits wide
// The BSR opcode is the only one the front end pre-decodes
// ====================
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// Fetch address and instruction word widths
`define FE_AW 32
`define FE_IW 32

// First fetch address after reset
`define FE_RST_PC 32'h0000_0100

// Opcode of the unconditional subroutine call
`define FE_OP_BSR 7'h6F

`endif

//--- hdl/fe_pkg.sv
// ====================
// Types shared by the front end blocks
// An instruction word is decoded either as an ALU format or a branch format
// The branch displacement counts words and is sign extended by the user
// ====================
`include "fe_defines.svh"

package fe_pkg;

	// A fetch address
	typedef logic [`FE_AW-1:0] pc_t;

	// Branch miss recovery sequence, idle first
	// Every state after BS_IDLE counts as recovering
	typedef enum logic [2:0] {
		BS_IDLE,
		BS_CHKPT_RESTORE,
		BS_RESTORE2,
		BS_DONE,
		BS_DONE2
	} branch_state_t;

	// Register to register format
	typedef struct packed {
		logic [`FE_IW-23:0] funct;
		logic [4:0]         rs2;
		logic [4:0]         rs1;
		logic [4:0]         rd;
		logic [6:0]         opcode;
	} alu_fmt_t;

	// Branch format with a word displacement in the upper bits
	typedef struct packed {
		logic [`FE_IW-8:0] disp;
		logic [6:0]        opcode;
	} br_fmt_t;

	// The opcode sits in the same bits in both views
	typedef union packed {
		alu_fmt_t alu;
		br_fmt_t  br;
	} insn_t;

endpackage

//--- hdl/edge_det.sv
// ====================
// Edge detector with a clock enable
// The sampled copy of i only moves when ce is high
// Edges are reported against that copy so they hold while ce is low
// ====================
module edge_det (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic i,
	output logic pe,
	output logic ne,
	output logic ee
);

	logic i_q;

	always_ff @(posedge clk) begin
		if (rst)
			i_q <= 1'b0;
		else if (ce)
			i_q <= i;
	end

	// Rising, falling and any change against the last enabled sample
	assign pe = i & ~i_q;
	assign ne = ~i & i_q;
	assign ee = i ^ i_q;

endmodule

//--- hdl/branch_recovery.sv
// ====================
// Branch miss recovery sequencer
// A miss is only taken in BS_IDLE, a miss during recovery is ignored
// The sequence always lasts four cycles after the miss cycle
// ====================
`include "fe_defines.svh"

module branch_recovery (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  branchmiss,
	input  fe_pkg::pc_t           misspc,
	output fe_pkg::branch_state_t branch_state,
	output fe_pkg::pc_t           miss_target
);

	fe_pkg::pc_t miss_q;
	logic        take_miss;

	assign take_miss = branchmiss && (branch_state == fe_pkg::BS_IDLE);

	// ====================
	// State walk
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			branch_state <= fe_pkg::BS_IDLE;
			miss_q <= `FE_RST_PC;
		end else begin
			case (branch_state)
				fe_pkg::BS_IDLE: begin
					if (take_miss) begin
						branch_state <= fe_pkg::BS_CHKPT_RESTORE;
						miss_q <= misspc;
					end
				end
				fe_pkg::BS_CHKPT_RESTORE: branch_state <= fe_pkg::BS_RESTORE2;
				fe_pkg::BS_RESTORE2:      branch_state <= fe_pkg::BS_DONE;
				fe_pkg::BS_DONE:          branch_state <= fe_pkg::BS_DONE2;
				default:                  branch_state <= fe_pkg::BS_IDLE;
			endcase
		end
	end

	// The miss address is forwarded in the miss cycle itself
	// This lets fetch be redirected by the same cycle's pulse
	assign miss_target = take_miss ? misspc : miss_q;

endmodule

//--- hdl/fetch_pc.sv
// ====================
// Fetch program counter
// Priority is redirect, then hold during a flush, then BSR, then step
// A missed fetch keeps the address so the word is asked for again
// ====================
`include "fe_defines.svh"

module fetch_pc (
	input  logic        clk,
	input  logic        rst,
	input  logic        advance,
	input  logic        ihit,
	input  logic        redirect,
	input  logic        stomp_pipeline,
	input  logic        do_bsr,
	input  fe_pkg::pc_t miss_target,
	input  fe_pkg::pc_t bsr_target,
	output fe_pkg::pc_t fetch_pc
);

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= `FE_RST_PC;
		end else if (redirect) begin
			// Branch miss recovery restarts at the miss address
			fetch_pc <= miss_target;
		end else if (!stomp_pipeline) begin
			// While the flush runs the address stays parked on the target
			if (do_bsr && advance)
				fetch_pc <= bsr_target;
			else if (advance && ihit)
				fetch_pc <= fetch_pc + fe_pkg::pc_t'(4);
		end
	end

endmodule

//--- hdl/frontend_pipe.sv
// ====================
// Stage registers from fetch to queue with BSR pre-decode
// Every stage moves together on advance, nothing moves otherwise
// A stage counts as live only when its valid bit is set and it is not stomped
// ====================
`include "fe_defines.svh"

module frontend_pipe (
	input  logic          clk,
	input  logic          rst,
	input  logic          advance,
	input  logic          ihit,
	input  fe_pkg::pc_t   fetch_pc,
	input  fe_pkg::insn_t fetch_insn,
	input  logic          stomp_fet,
	input  logic          stomp_mux,
	input  logic          stomp_dec,
	input  logic          stomp_ren,
	input  logic          stomp_que,
	output logic          do_bsr,
	output fe_pkg::pc_t   bsr_target,
	output logic          que_valid,
	output fe_pkg::pc_t   que_pc,
	output fe_pkg::insn_t que_insn
);

	// Stage 0 is fetch and stage 4 is queue
	localparam int NSTAGE = 5;

	fe_pkg::pc_t       pc_q   [NSTAGE];
	fe_pkg::insn_t     insn_q [NSTAGE];
	logic [NSTAGE-1:0] v_q;
	logic [NSTAGE-1:0] stomp;
	logic [NSTAGE-1:0] live;
	logic [`FE_IW-8:0] disp;

	assign stomp = {stomp_que, stomp_ren, stomp_dec, stomp_mux, stomp_fet};
	assign live = v_q & ~stomp;

	// ====================
	// Payload
	// ====================
	always_ff @(posedge clk) begin
		if (advance) begin
			pc_q[0] <= fetch_pc;
			insn_q[0] <= fetch_insn;
			for (int s = 1; s < NSTAGE; s++) begin
				pc_q[s] <= pc_q[s-1];
				insn_q[s] <= insn_q[s-1];
			end
		end
	end

	// A fetch without a hit enters as a bubble
	// A stomped stage hands an empty slot to the next one
	always_ff @(posedge clk) begin
		if (rst)
			v_q <= '0;
		else if (advance)
			v_q <= {live[NSTAGE-2:0], ihit};
	end

	// ====================
	// BSR pre-decode at fetch
	// ====================
	assign do_bsr = live[0] && (insn_q[0].alu.opcode == `FE_OP_BSR);

	// Target is the BSR address plus four times the signed word displacement
	assign disp = insn_q[0].br.disp;
	assign bsr_target = pc_q[0] + {{(`FE_AW-`FE_IW+5){disp[`FE_IW-8]}}, disp, 2'b00};

	// Queue port
	assign que_valid = live[NSTAGE-1] & advance;
	assign que_pc = pc_q[NSTAGE-1];
	assign que_insn = insn_q[NSTAGE-1];

endmodule

//--- hdl/stomp_ctrl.sv
// ====================
// Stomp waterfall for the five front end stages
// Each flag belongs to the word currently held in its stage
// Flags move with the stage registers and also on a redirect pulse
// A queued word is dropped when stomped, it is never turned into a copy
// ====================
module stomp_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  advance,
	input  logic                  branchmiss,
	input  fe_pkg::branch_state_t branch_state,
	input  logic                  do_bsr,
	output logic                  stomp_fet,
	output logic                  stomp_mux,
	output logic                  stomp_dec,
	output logic                  stomp_ren,
	output logic                  stomp_que,
	output logic                  stomp_pipeline,
	output logic                  redirect
);

	// Bit 0 is fetch and bit 4 is queue
	logic [4:0] flag_q;
	logic [4:0] flag_d;
	logic [4:0] flag;
	logic       recovering;
	logic       ed_ce;

	// ====================
	// Flush level and redirect pulse
	// ====================

	// Any state past idle belongs to the recovery sequence
	assign recovering = (branch_state >= fe_pkg::BS_CHKPT_RESTORE) &&
		(branch_state <= fe_pkg::BS_DONE2);

	// The flush starts in the miss cycle itself and ends with recovery
	assign stomp_pipeline = branchmiss | recovering;

	// The detector samples on every advance
	// The pulse also clocks it, so the pulse stays one cycle under back-pressure
	assign ed_ce = advance | redirect;

	edge_det u_edge_det (
		.clk (clk),
		.rst (rst),
		.ce  (ed_ce),
		.i   (stomp_pipeline),
		.pe  (redirect),
		.ne  (),
		.ee  ()
	);

	// ====================
	// Waterfall
	// ====================

	// The word entering fetch is stomped during a flush
	// It is also stomped when it is the word behind a BSR at fetch
	// That shadow word then carries its flag down the later stages
	assign flag_d[0] = stomp_pipeline | do_bsr;

	// Later stages inherit the flag of the stage before them
	// A flush in progress sets every stage as it is loaded
	assign flag_d[4:1] = {4{stomp_pipeline}} | flag[3:0];

	// Registers move with the pipe, or on the pulse alone when stalled
	// In that case the held words are squashed where they sit
	always_ff @(posedge clk) begin
		if (rst)
			flag_q <= '1;
		else if (advance || redirect)
			flag_q <= flag_d;
	end

	// The pulse kills the words already past fetch in the same cycle
	// so that none of them is handed on or accepted at the queue port
	assign flag[0] = flag_q[0];
	assign flag[4:1] = flag_q[4:1] | {4{redirect}};

	assign stomp_fet = flag[0];
	assign stomp_mux = flag[1];
	assign stomp_dec = flag[2];
	assign stomp_ren = flag[3];
	assign stomp_que = flag[4];

endmodule

//--- hdl/frontend_top.sv
// ====================
// Instruction front end top level
// The queue port stalls the whole pipe, there is no other stall
// Only one branch miss may be in recovery at a time
// ====================
module frontend_top (
	input  logic          clk,
	input  logic          rst,
	input  logic          ihit,
	input  logic          branchmiss,
	input  logic          que_ready,
	input  fe_pkg::pc_t   misspc,
	input  fe_pkg::insn_t fetch_insn,
	output fe_pkg::pc_t   fetch_pc,
	output logic          que_valid,
	output fe_pkg::pc_t   que_pc,
	output fe_pkg::insn_t que_insn
);

	logic                  advance;
	fe_pkg::branch_state_t branch_state;
	fe_pkg::pc_t           miss_target;
	fe_pkg::pc_t           bsr_target;
	logic                  do_bsr;
	logic                  stomp_fet;
	logic                  stomp_mux;
	logic                  stomp_dec;
	logic                  stomp_ren;
	logic                  stomp_que;
	logic                  stomp_pipeline;
	logic                  redirect;

	// Both pipe segments follow the same queue back-pressure
	assign advance = que_ready;

	branch_recovery u_branch_recovery (
		.clk          (clk),
		.rst          (rst),
		.branchmiss   (branchmiss),
		.misspc       (misspc),
		.branch_state (branch_state),
		.miss_target  (miss_target)
	);

	stomp_ctrl u_stomp_ctrl (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.branchmiss     (branchmiss),
		.branch_state   (branch_state),
		.do_bsr         (do_bsr),
		.stomp_fet      (stomp_fet),
		.stomp_mux      (stomp_mux),
		.stomp_dec      (stomp_dec),
		.stomp_ren      (stomp_ren),
		.stomp_que      (stomp_que),
		.stomp_pipeline (stomp_pipeline),
		.redirect       (redirect)
	);

	fetch_pc u_fetch_pc (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.ihit           (ihit),
		.redirect       (redirect),
		.stomp_pipeline (stomp_pipeline),
		.do_bsr         (do_bsr),
		.miss_target    (miss_target),
		.bsr_target     (bsr_target),
		.fetch_pc       (fetch_pc)
	);

	frontend_pipe u_frontend_pipe (
		.clk        (clk),
		.rst        (rst),
		.advance    (advance),
		.ihit       (ihit),
		.fetch_pc   (fetch_pc),
		.fetch_insn (fetch_insn),
		.stomp_fet  (stomp_fet),
		.stomp_mux  (stomp_mux),
		.stomp_dec  (stomp_dec),
		.stomp_ren  (stomp_ren),
		.stomp_que  (stomp_que),
		.do_bsr     (do_bsr),
		.bsr_target (bsr_target),
		.que_valid  (que_valid),
		.que_pc     (que_pc),
		.que_insn   (que_insn)
	);

endmodule

//--- testbench/tb_clock.sv
// ====================
// Free running clock for the testbench
// Starts low, so the first rising edge is half a period in
// ====================
module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

//--- testbench/frontend_asserts.sv
// ====================
// Concurrent checks on the stomp waterfall
// Bound into every stomp_ctrl instance
// ====================
module frontend_asserts (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic redirect,
	input logic stomp_pipeline,
	input logic stomp_fet,
	input logic stomp_mux,
	input logic stomp_dec,
	input logic stomp_ren,
	input logic stomp_que
);

	logic all_stomped;

	assign all_stomped = stomp_fet & stomp_mux & stomp_dec & stomp_ren & stomp_que;

	// A reset edge leaves every stage squashed
	reset_flags: assert property (@(posedge clk) rst |=> all_stomped)
		else $error("stomp flags not all set in the cycle after reset");

	// The redirect pulse clocks its own detector, so it can never stretch
	single_redirect: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
		else $error("redirect stayed high for two cycles");

	// A word loaded into fetch during a flush must carry a stomp flag
	flush_reaches_fetch: assert property (@(posedge clk) disable iff (rst)
		(stomp_pipeline && advance) |=> stomp_fet)
		else $error("stomp_fet low after an advance during a flush");

endmodule

//--- testbench/frontend_tb.sv
// ====================
// Directed testbench for the instruction front end
// Inputs change on the rising edge and the queue port is logged on that same edge
// The memory model answers in the same cycle and ihit is a pure stimulus bit
// Each test starts from reset and issues at most one branch miss
// ====================
`include "fe_defines.svh"

module frontend_tb;

	// Worst case cycles of each test, with a margin added for the watchdog
	localparam int BUDGET_RESET = 30;
	localparam int BUDGET_STRAIGHT = 40;
	localparam int BUDGET_RANDOM = 210;
	localparam int BUDGET_BSR = 60;
	localparam int BUDGET_MISS = 80;
	localparam int BUDGET_MISS_STALL = 90;
	localparam int WATCHDOG_CYCLES = BUDGET_RESET + BUDGET_STRAIGHT + BUDGET_RANDOM +
		BUDGET_BSR + BUDGET_MISS + BUDGET_MISS_STALL + 100;

	logic          clk;
	logic          rst;
	logic          ihit;
	logic          branchmiss;
	logic          que_ready;
	fe_pkg::pc_t   misspc;
	fe_pkg::insn_t fetch_insn;
	fe_pkg::pc_t   fetch_pc;
	logic          que_valid;
	fe_pkg::pc_t   que_pc;
	fe_pkg::insn_t que_insn;

	// The one BSR word the memory model may hold
	logic        bsr_en;
	logic [31:0] bsr_pc;
	logic [24:0] bsr_disp;

	// Accepted queue entries carry the number of misses seen so far
	logic [31:0] acc_pc [$];
	logic [31:0] acc_insn [$];
	int          acc_tag [$];
	int          acc_cyc [$];
	int          fetch_cyc [logic [31:0]];
	int          cycle;
	int          miss_count;
	int          fetch_count;

	// Log positions at the end of the latest reset
	int          base;
	int          miss_tag;
	int          fetch_base;
	int          errors;
	int          checks;
	int          tests_run;
	logic [15:0] lfsr_state;

	tb_clock #(.PERIOD(20)) clock0 (.clk(clk));

	frontend_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.ihit       (ihit),
		.branchmiss (branchmiss),
		.que_ready  (que_ready),
		.misspc     (misspc),
		.fetch_insn (fetch_insn),
		.fetch_pc   (fetch_pc),
		.que_valid  (que_valid),
		.que_pc     (que_pc),
		.que_insn   (que_insn)
	);

	bind stomp_ctrl frontend_asserts asserts0 (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.redirect       (redirect),
		.stomp_pipeline (stomp_pipeline),
		.stomp_fet      (stomp_fet),
		.stomp_mux      (stomp_mux),
		.stomp_dec      (stomp_dec),
		.stomp_ren      (stomp_ren),
		.stomp_que      (stomp_que)
	);

	// ====================
	// Models
	// ====================

	// Plain words mix every address bit into the upper field and never carry the BSR opcode
	function automatic logic [31:0] insn_at(input logic [31:0] pc, input logic en,
		input logic [31:0] bpc, input logic [24:0] disp);
		if (en && pc == bpc)
			return {disp, `FE_OP_BSR};
		return {pc[31:7] ^ pc[24:0] ^ 25'h1A5_C3E, 7'h33};
	endfunction

	assign fetch_insn = insn_at(fetch_pc, bsr_en, bsr_pc, bsr_disp);

	// In program order a BSR jumps by four times its signed word displacement
	function automatic logic [31:0] next_pc(input logic [31:0] pc);
		int words;
		words = $signed(bsr_disp);
		if (bsr_en && pc == bsr_pc)
			return bsr_pc + 32'(words * 4);
		return pc + 32'd4;
	endfunction

	// 16 bit Fibonacci LFSR with taps at 16 14 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	// ====================
	// Check and report helpers
	// ====================
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report_error(input string name, input string what);
		errors++;
		$display("%s: %s", name, what);
	endtask

	task automatic finish_test(input string name, input int start_err);
		tests_run++;
		$display("test %s finished with %0d errors", name, errors - start_err);
	endtask

	// Gives five reset edges and expects que_valid low once the first one has landed
	task automatic apply_reset(input string name);
		@(posedge clk);
		rst <= 1'b1;
		ihit <= 1'b1;
		que_ready <= 1'b1;
		branchmiss <= 1'b0;
		bsr_en <= 1'b0;
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			if (i > 0)
				check(name, 32'd0, 32'(que_valid));
		end
		// The monitor is idle during reset, so the log sizes are settled here
		base = acc_pc.size();
		miss_tag = miss_count;
		fetch_base = fetch_count;
		rst <= 1'b0;
	endtask

	task automatic wait_accepts(input string name, input int n, input int max_cycles);
		int waited = 0;
		while (acc_pc.size() < n && waited < max_cycles) begin
			@(negedge clk);
			waited++;
		end
		if (acc_pc.size() < n)
			report_error(name, "too few instructions were accepted before the time limit");
	endtask

	// Walks the entries of one tag and compares them with program order from start
	task automatic check_stream(input string name, input int tag, input logic [31:0] start);
		logic [31:0] pc = start;
		int          found = 0;
		for (int i = base; i < acc_pc.size(); i++) begin
			if (acc_tag[i] == tag) begin
				check(name, pc, acc_pc[i]);
				check(name, insn_at(pc, bsr_en, bsr_pc, bsr_disp), acc_insn[i]);
				pc = next_pc(pc);
				found++;
			end
		end
		if (found == 0)
			report_error(name, "no instruction was accepted in a checked stretch");
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset();
		string name = "reset";
		int    start_err = errors;
		apply_reset(name);
		wait_accepts(name, base + 1, 20);
		if (acc_pc.size() > base)
			check(name, `FE_RST_PC, acc_pc[base]);
		finish_test(name, start_err);
	endtask

	task automatic test_straight();
		string name = "straight_line";
		int    start_err = errors;
		apply_reset(name);
		wait_accepts(name, base + 12, 30);
		check_stream(name, miss_tag, `FE_RST_PC);
		// Fetch to queue takes exactly five edges with no stall
		for (int i = base; i < acc_pc.size(); i++) begin
			if (fetch_cyc.exists(acc_pc[i]))
				check(name, 32'd5, 32'(acc_cyc[i] - fetch_cyc[acc_pc[i]]));
			else
				report_error(name, "an accepted address was never fetched");
		end
		finish_test(name, start_err);
	endtask

	task automatic test_random();
		string name = "hit_and_stall";
		int    start_err = errors;
		int    n;
		logic  b;
		apply_reset(name);
		for (int i = 0; i < 160; i++) begin
			@(posedge clk);
			take_bit(b);
			ihit <= b;
			take_bit(b);
			que_ready <= b;
		end
		// Fetching stops and the pipe drains so every hit fetch must come out once
		@(posedge clk);
		ihit <= 1'b0;
		que_ready <= 1'b1;
		@(negedge clk);
		n = fetch_count - fetch_base;
		wait_accepts(name, base + n, 20);
		check_stream(name, miss_tag, `FE_RST_PC);
		check(name, 32'(n), 32'(acc_pc.size() - base));
		finish_test(name, start_err);
	endtask

	task automatic test_bsr();
		string name = "bsr";
		int    start_err = errors;
		int    shadow = 0;
		apply_reset(name);
		// The BSR jumps back by sixteen words, so its target lies below the reset address
		bsr_en <= 1'b1;
		bsr_pc <= 32'h0000_0114;
		bsr_disp <= 25'h1FF_FFF0;
		wait_accepts(name, base + 16, 50);
		check_stream(name, miss_tag, `FE_RST_PC);
		for (int i = base; i < acc_pc.size(); i++) begin
			if (acc_pc[i] == 32'h0000_0118)
				shadow++;
		end
		check(name, 32'd0, 32'(shadow));
		finish_test(name, start_err);
	endtask

	// Issues a miss with the queue open or two cycles into a stall
	task automatic test_miss(input string name, input logic stalled, input logic [31:0] target);
		int start_err = errors;
		int after;
		apply_reset(name);
		wait_accepts(name, base + 6, 30);
		@(posedge clk);
		if (stalled) begin
			que_ready <= 1'b0;
			repeat (2) @(posedge clk);
		end
		branchmiss <= 1'b1;
		misspc <= target;
		@(posedge clk);
		branchmiss <= 1'b0;
		if (stalled) begin
			repeat (7) @(posedge clk);
			que_ready <= 1'b1;
		end
		@(negedge clk);
		after = acc_pc.size();
		wait_accepts(name, after + 8, 40);
		check_stream(name, miss_tag, `FE_RST_PC);
		check_stream(name, miss_tag + 1, target);
		finish_test(name, start_err);
	endtask

	// ====================
	// Sequence, monitor and watchdog
	// ====================
	initial begin
		rst <= 1'b1;
		ihit <= 1'b0;
		branchmiss <= 1'b0;
		que_ready <= 1'b0;
		misspc <= '0;
		bsr_en <= 1'b0;
		bsr_pc <= '0;
		bsr_disp <= '0;
		lfsr_state = 16'd48545;
		test_reset();
		test_straight();
		test_random();
		test_bsr();
		test_miss("branch_miss", 1'b0, 32'h0000_0800);
		test_miss("miss_stalled", 1'b1, 32'h0000_2000);
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Logs fetches and accepted entries as the DUT sees them on this edge
	always @(posedge clk) begin
		if (!rst) begin
			if (branchmiss)
				miss_count++;
			if (que_ready && ihit) begin
				fetch_cyc[fetch_pc] = cycle;
				fetch_count++;
			end
			if (que_valid && que_ready) begin
				acc_pc.push_back(que_pc);
				acc_insn.push_back(que_insn);
				acc_tag.push_back(miss_count);
				acc_cyc.push_back(cycle);
			end
		end
		cycle++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- compile.f
+incdir+hdl
hdl/fe_pkg.sv
hdl/edge_det.sv
hdl/branch_recovery.sv
hdl/fetch_pc.sv
hdl/frontend_pipe.sv
hdl/stomp_ctrl.sv
hdl/frontend_top.sv
testbench/tb_clock.sv
testbench/frontend_asserts.sv
testbench/frontend_tb.sv

//--- run.sh
#!/bin/sh
# Builds the front end testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module frontend_tb -f compile.f -o frontend_sim
out=$(./obj_dir/frontend_sim)
echo "$out"
if echo "$out" | grep -qx "Result: PASSED"; then
	exit 0
fi
echo "run.sh: simulation did not report a pass"
exit 1
